//--- hdl/icache_pkg.sv
// shared geometry constants and controller state encoding for the instruction cache
package icache_pkg;

    // fetch side widths
    localparam int ADDR_W = 32;          // byte address from fetch unit
    localparam int WORD_W = 32;          // one instruction word

    // line geometry
    localparam int WORDS_PER_LINE = 4;   // beats per refill
    localparam int LINE_W = 128;         // WORDS_PER_LINE * WORD_W
    localparam int OFFSET_BITS = 4;      // byte offset inside a line

    // controller states
    // ST_IDLE leaves after one cycle, ST_WRITE_LINE is a single-cycle fill
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,            // after reset
        ST_LOOKUP     = 3'd1,            // compare tags
        ST_WAIT_L2    = 3'd2,            // second level busy
        ST_REFILL     = 3'd3,            // collecting beats
        ST_WRITE_LINE = 3'd4             // write victim way
    } ctrl_state_t;

endpackage

//--- hdl/cache_array_if.sv
// lookup and fill bundle between the cache controller and the tag and data arrays
`timescale 1ns/1ps

interface cache_array_if #(
    parameter int INDEX_BITS = 8
) ();
    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_BITS - icache_pkg::OFFSET_BITS;

    // controller to arrays
    logic [INDEX_BITS-1:0]         index;      // set being looked up or filled
    logic [TAG_W-1:0]              fill_tag;
    logic [icache_pkg::LINE_W-1:0] fill_line;
    logic [1:0]                    way_we;     // one bit per way
    logic                          touch;      // hit this cycle
    logic                          touch_way;

    // arrays to controller, combinational reads
    logic [TAG_W-1:0]              tag0;
    logic [TAG_W-1:0]              tag1;
    logic                          valid0;
    logic                          valid1;
    logic                          lru;        // way to replace next
    logic [icache_pkg::LINE_W-1:0] line0;
    logic [icache_pkg::LINE_W-1:0] line1;

    modport ctrl (
        output index, fill_tag, fill_line, way_we, touch, touch_way,
        input  tag0, tag1, valid0, valid1, lru, line0, line1
    );

    modport tags (
        input  index, fill_tag, way_we, touch, touch_way,
        output tag0, tag1, valid0, valid1, lru
    );

    modport data (
        input  index, fill_line, way_we,
        output line0, line1
    );

endinterface

//--- hdl/icache_ctrl.sv
// instruction cache FSM: hit detect, word select, miss stall, L2 request and victim choice
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int INDEX_BITS = 8
) (
    input  logic                          clk_tmp,
    input  logic                          reset,
    // fetch side
    input  logic                          fetch_req,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    output logic [icache_pkg::WORD_W-1:0] fetch_data,
    output logic                          fetch_done,
    output logic                          miss_stall,
    // second level side
    input  logic                          l2_busy,
    input  logic                          l2_rdy,       // first beat ends the request
    output logic                          l2_req,
    output logic [icache_pkg::ADDR_W-1:0] l2_addr,
    // refill counter link
    output logic                          refill_start,
    input  logic                          line_done,
    input  logic [icache_pkg::LINE_W-1:0] fill_line_in,
    // arrays
    cache_array_if.ctrl                   arr
);
    localparam int TAG_W  = icache_pkg::ADDR_W - INDEX_BITS - icache_pkg::OFFSET_BITS;
    localparam int WSEL_W = $clog2(icache_pkg::WORDS_PER_LINE);

    icache_pkg::ctrl_state_t       state;
    logic [TAG_W-1:0]              addr_tag;
    logic [INDEX_BITS-1:0]         addr_index;
    logic [WSEL_W-1:0]             word_sel;
    logic                          hit0;
    logic                          hit1;
    logic                          hit;
    logic                          hit_way;
    logic                          lookup_go;
    logic                          lookup_hit;
    logic [icache_pkg::LINE_W-1:0] hit_line;
    logic                          victim_pick;
    logic                          victim_way;

    // address split
    assign addr_tag   = fetch_addr[icache_pkg::ADDR_W-1 -: TAG_W];
    assign addr_index = fetch_addr[icache_pkg::OFFSET_BITS +: INDEX_BITS];
    assign word_sel   = fetch_addr[icache_pkg::OFFSET_BITS-1 -: WSEL_W];

    // tag compare on both ways
    assign hit0    = arr.valid0 && (arr.tag0 == addr_tag);
    assign hit1    = arr.valid1 && (arr.tag1 == addr_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1 && !hit0;                      // way 0 wins a double match
    assign hit_line = hit_way ? arr.line1 : arr.line0;

    // no lookup while fetch_done is still up for the last access
    assign lookup_go  = (state == icache_pkg::ST_LOOKUP) && fetch_req && !fetch_done;
    assign lookup_hit = lookup_go && hit;

    // first invalid way, otherwise lru
    assign victim_pick = !arr.valid0 ? 1'b0 : (!arr.valid1 ? 1'b1 : arr.lru);

    // array control
    assign arr.index     = addr_index;
    assign arr.fill_tag  = addr_tag;
    assign arr.fill_line = fill_line_in;
    assign arr.touch     = lookup_hit;
    assign arr.touch_way = hit_way;

    always_comb begin
        arr.way_we = 2'b00;
        if (state == icache_pkg::ST_WRITE_LINE) begin
            arr.way_we[victim_way] = 1'b1;
        end
    end

    // counter is cleared on the edge where l2_req goes up
    assign refill_start = (state == icache_pkg::ST_WAIT_L2) && !l2_busy;

    // line aligned request address, fetch holds fetch_addr through the miss
    assign l2_addr = {fetch_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_BITS],
                      {icache_pkg::OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk_tmp) begin
        if (reset) begin
            state      <= icache_pkg::ST_IDLE;
            fetch_done <= 1'b0;
            miss_stall <= 1'b0;
            l2_req     <= 1'b0;
            victim_way <= 1'b0;
        end else begin
            fetch_done <= 1'b0;                          // single cycle pulse
            case (state)
                icache_pkg::ST_IDLE: begin
                    state <= icache_pkg::ST_LOOKUP;
                end
                icache_pkg::ST_LOOKUP: begin
                    if (lookup_go) begin
                        if (hit) begin
                            fetch_done <= 1'b1;
                        end else begin
                            miss_stall <= 1'b1;
                            state      <= icache_pkg::ST_WAIT_L2;
                        end
                    end
                end
                icache_pkg::ST_WAIT_L2: begin
                    if (!l2_busy) begin
                        l2_req <= 1'b1;
                        state  <= icache_pkg::ST_REFILL;
                    end
                end
                icache_pkg::ST_REFILL: begin
                    if (l2_rdy) begin
                        l2_req <= 1'b0;                  // dropped at first beat
                    end
                    if (line_done) begin
                        victim_way <= victim_pick;
                        state      <= icache_pkg::ST_WRITE_LINE;
                    end
                end
                icache_pkg::ST_WRITE_LINE: begin
                    miss_stall <= 1'b0;
                    state      <= icache_pkg::ST_LOOKUP;  // retry, now hits
                end
                default: begin
                    state <= icache_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // selected word of the hit line
    always_ff @(posedge clk_tmp) begin
        if (lookup_hit) begin
            fetch_data <= hit_line[word_sel*icache_pkg::WORD_W +: icache_pkg::WORD_W];
        end
    end

endmodule

//--- hdl/refill_counter.sv
// collects the four L2 beats of a refill into one cache line and flags completion
`timescale 1ns/1ps

module refill_counter (
    input  logic                          clk_tmp,
    input  logic                          reset,
    input  logic                          refill_start,  // clears the beat count
    input  logic                          l2_rdy,
    input  logic [icache_pkg::WORD_W-1:0] l2_data,
    output logic                          line_done,
    output logic [icache_pkg::LINE_W-1:0] fill_line
);
    localparam int CNT_W = $clog2(icache_pkg::WORDS_PER_LINE);

    logic [CNT_W-1:0] beat_cnt;
    logic             active;
    logic             beat_ok;
    logic             last_beat;

    assign beat_ok   = active && l2_rdy;                  // stray l2_rdy ignored
    assign last_beat = beat_ok && (beat_cnt == CNT_W'(icache_pkg::WORDS_PER_LINE - 1));

    always_ff @(posedge clk_tmp) begin
        if (reset) begin
            beat_cnt  <= '0;
            active    <= 1'b0;
            line_done <= 1'b0;
        end else begin
            line_done <= last_beat;                       // one cycle after last beat
            if (refill_start) begin
                beat_cnt <= '0;
                active   <= 1'b1;
            end else if (beat_ok) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // lowest offset arrives first
    always_ff @(posedge clk_tmp) begin
        if (beat_ok) begin
            fill_line[beat_cnt*icache_pkg::WORD_W +: icache_pkg::WORD_W] <= l2_data;
        end
    end

endmodule

//--- hdl/icache_tag_array.sv
// per-way tag and valid storage with one LRU bit per set, read combinationally
`timescale 1ns/1ps

module icache_tag_array #(
    parameter int INDEX_BITS = 8
) (
    input  logic        clk_tmp,
    input  logic        reset,
    cache_array_if.tags arr
);
    localparam int SETS  = 1 << INDEX_BITS;
    localparam int TAG_W = icache_pkg::ADDR_W - INDEX_BITS - icache_pkg::OFFSET_BITS;

    logic [TAG_W-1:0] tag_mem [2][SETS];
    logic [SETS-1:0]  valid_q [2];
    logic [SETS-1:0]  lru_q;                             // 1 means replace way 1

    for (genvar w = 0; w < 2; w++) begin : g_way
        // tag payload
        always_ff @(posedge clk_tmp) begin
            if (arr.way_we[w]) begin
                tag_mem[w][arr.index] <= arr.fill_tag;
            end
        end

        always_ff @(posedge clk_tmp) begin
            if (reset) begin
                valid_q[w] <= '0;
            end else if (arr.way_we[w]) begin
                valid_q[w][arr.index] <= 1'b1;
            end
        end
    end

    // hit or fill points lru at the other way
    always_ff @(posedge clk_tmp) begin
        if (reset) begin
            lru_q <= '0;
        end else if (arr.touch) begin
            lru_q[arr.index] <= ~arr.touch_way;
        end else if (arr.way_we[0]) begin
            lru_q[arr.index] <= 1'b1;
        end else if (arr.way_we[1]) begin
            lru_q[arr.index] <= 1'b0;
        end
    end

    assign arr.tag0   = tag_mem[0][arr.index];
    assign arr.tag1   = tag_mem[1][arr.index];
    assign arr.valid0 = valid_q[0][arr.index];
    assign arr.valid1 = valid_q[1][arr.index];
    assign arr.lru    = lru_q[arr.index];

endmodule

//--- hdl/icache_data_array.sv
// per-way 128-bit line storage, both ways read combinationally at the current index
`timescale 1ns/1ps

module icache_data_array #(
    parameter int INDEX_BITS = 8
) (
    input  logic        clk_tmp,
    cache_array_if.data arr
);
    localparam int SETS = 1 << INDEX_BITS;

    logic [icache_pkg::LINE_W-1:0] line_mem [2][SETS];

    // a fill writes exactly one way
    for (genvar w = 0; w < 2; w++) begin : g_way
        always_ff @(posedge clk_tmp) begin
            if (arr.way_we[w]) begin
                line_mem[w][arr.index] <= arr.fill_line;
            end
        end
    end

    assign arr.line0 = line_mem[0][arr.index];
    assign arr.line1 = line_mem[1][arr.index];

endmodule

//--- hdl/icache_top.sv
// two-way instruction cache top level, wires controller, refill counter and arrays
`timescale 1ns/1ps

module icache_top #(
    parameter int INDEX_BITS = 8
) (
    input  logic                          clk_tmp,
    input  logic                          reset,
    // fetch unit
    input  logic                          fetch_req,
    input  logic [icache_pkg::ADDR_W-1:0] fetch_addr,
    output logic [icache_pkg::WORD_W-1:0] fetch_data,
    output logic                          fetch_done,
    output logic                          miss_stall,
    // second level memory
    input  logic                          l2_busy,
    input  logic                          l2_rdy,
    input  logic [icache_pkg::WORD_W-1:0] l2_data,
    output logic                          l2_req,
    output logic [icache_pkg::ADDR_W-1:0] l2_addr
);
    logic                          refill_start;
    logic                          line_done;
    logic [icache_pkg::LINE_W-1:0] fill_line;

    cache_array_if #(.INDEX_BITS(INDEX_BITS)) arr_if ();

    icache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
        .clk_tmp      (clk_tmp),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_done   (fetch_done),
        .miss_stall   (miss_stall),
        .l2_busy      (l2_busy),
        .l2_rdy       (l2_rdy),
        .l2_req       (l2_req),
        .l2_addr      (l2_addr),
        .refill_start (refill_start),
        .line_done    (line_done),
        .fill_line_in (fill_line),
        .arr          (arr_if.ctrl)
    );

    refill_counter u_refill (
        .clk_tmp      (clk_tmp),
        .reset        (reset),
        .refill_start (refill_start),
        .l2_rdy       (l2_rdy),
        .l2_data      (l2_data),
        .line_done    (line_done),
        .fill_line    (fill_line)
    );

    icache_tag_array #(.INDEX_BITS(INDEX_BITS)) u_tags (
        .clk_tmp (clk_tmp),
        .reset   (reset),
        .arr     (arr_if.tags)
    );

    icache_data_array #(.INDEX_BITS(INDEX_BITS)) u_data (
        .clk_tmp (clk_tmp),
        .arr     (arr_if.data)
    );

endmodule

//--- bench/icache_tb.sv
// testbench for the instruction cache, runs a fetch table against a modelled L2 memory
`timescale 1ns/1ps

module icache_tb;
    localparam int NUM_ENTRIES = 15;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 64;
    localparam logic [31:0] MEM_KEY = 32'hC0DE_0000;     // l2 word = byte address ^ key

    typedef struct packed {
        logic [31:0] addr;
        logic        exp_miss;
        logic        busy_hold;                          // hold l2_busy at the miss
        logic        reset_first;                        // reset before this access
    } stim_t;

    // index is addr[11:4], tag is addr[31:12]
    localparam stim_t STIM [NUM_ENTRIES] = '{
        '{32'h0000_1040, 1'b1, 1'b0, 1'b0},              // cold, fills way 0
        '{32'h0000_1048, 1'b0, 1'b0, 1'b0},              // same line
        '{32'h0000_2044, 1'b1, 1'b0, 1'b0},              // same index, fills way 1
        '{32'h0000_104c, 1'b0, 1'b0, 1'b0},
        '{32'h0000_2040, 1'b0, 1'b0, 1'b0},
        '{32'h0000_104c, 1'b0, 1'b0, 1'b0},              // touch way 0, lru now way 1
        '{32'h0000_3040, 1'b1, 1'b0, 1'b0},              // evicts tag 2
        '{32'h0000_1044, 1'b0, 1'b0, 1'b0},              // way 0 kept
        '{32'h0000_2048, 1'b1, 1'b1, 1'b0},              // tag 2 was evicted
        '{32'h0000_5a3c, 1'b1, 1'b1, 1'b0},
        '{32'h0000_5a30, 1'b0, 1'b0, 1'b0},
        '{32'h0000_1040, 1'b1, 1'b0, 1'b1},              // cached before the reset
        '{32'h0000_1044, 1'b0, 1'b0, 1'b0},
        '{32'hffff_fff0, 1'b1, 1'b0, 1'b0},              // last set
        '{32'hffff_fffc, 1'b0, 1'b0, 1'b0}
    };

    logic        clk_tmp = 1'b0;
    logic        reset;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;
    logic        fetch_done;
    logic        miss_stall;
    logic        l2_busy;
    logic        l2_rdy;
    logic [31:0] l2_data;
    logic        l2_req;
    logic [31:0] l2_addr;

    integer seed = 32'h5f81;
    int     errors = 0;
    int     checks = 0;
    int     req_count = 0;                               // l2_req rising edges
    int     cycle_cnt = 0;
    logic   busy_flag = 1'b0;

    icache_top #(.INDEX_BITS(8)) dut (
        .clk_tmp    (clk_tmp),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .fetch_done (fetch_done),
        .miss_stall (miss_stall),
        .l2_busy    (l2_busy),
        .l2_rdy     (l2_rdy),
        .l2_data    (l2_data),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr)
    );

    always #2 clk_tmp = ~clk_tmp;                        // 4 ns period

    always @(posedge clk_tmp) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT never finished the access", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
        errors = errors + 1;
    endtask

    // L2 model, busy stretches and beats with random gaps
    initial begin
        int          beat_idx;
        int          busy_left;
        logic        serving;
        logic        req_q;
        logic        stall_q;
        logic [31:0] line_base;
        logic [31:0] r;
        l2_busy   = 1'b0;
        l2_rdy    = 1'b0;
        l2_data   = '0;
        beat_idx  = 0;
        busy_left = 0;
        serving   = 1'b0;
        req_q     = 1'b0;
        stall_q   = 1'b0;
        line_base = '0;
        forever begin
            @(posedge clk_tmp);
            #1;
            if (reset) begin
                serving   = 1'b0;
                l2_rdy    = 1'b0;
                l2_busy   = 1'b0;
                busy_left = 0;
                req_q     = 1'b0;
                stall_q   = 1'b0;
            end else begin
                if (serving && l2_rdy) begin
                    beat_idx = beat_idx + 1;             // beat taken at this edge
                end
                if (l2_req && !req_q) begin
                    req_count = req_count + 1;
                    checks = checks + 1;
                    if (l2_busy) begin
                        $display("t=%0t l2_req went high while l2_busy was high", $time);
                        errors = errors + 1;
                    end
                    checks = checks + 1;
                    if (l2_addr != {fetch_addr[31:4], 4'h0}) begin
                        value_mismatch("l2_addr", l2_addr, {fetch_addr[31:4], 4'h0});
                    end
                    line_base = {l2_addr[31:4], 4'h0};
                    serving   = 1'b1;
                    beat_idx  = 0;
                end
                if (serving) begin
                    checks = checks + 1;
                    if (l2_req != (beat_idx == 0)) begin
                        $display("t=%0t l2_req not high exactly until the first beat", $time);
                        errors = errors + 1;
                    end
                end
                if (serving && beat_idx == 4) begin
                    serving = 1'b0;
                end
                if (serving) begin
                    r       = $random(seed);
                    l2_rdy  = (r[1:0] != 2'b00);         // about one gap in four
                    l2_data = (line_base | 32'(beat_idx * 4)) ^ MEM_KEY;
                end else begin
                    l2_rdy = 1'b0;
                end
                req_q = l2_req;
                if (miss_stall && !stall_q && busy_flag) begin
                    r         = $random(seed);
                    l2_busy   = 1'b1;
                    busy_left = 4 + int'(r[2:0]);
                end else if (busy_left > 0) begin
                    busy_left = busy_left - 1;
                    if (busy_left == 0) begin
                        l2_busy = 1'b0;
                    end
                end
                stall_q = miss_stall;
            end
        end
    end

    task automatic apply_reset();
        reset     = 1'b1;
        fetch_req = 1'b0;
        repeat (5) @(posedge clk_tmp);
        #1;
        reset = 1'b0;
        checks = checks + 1;
        if (fetch_done || miss_stall || l2_req) begin
            $display("t=%0t outputs not low after reset", $time);
            errors = errors + 1;
        end
        @(posedge clk_tmp);                              // idle to lookup
        #1;
    endtask

    task automatic run_access(input stim_t e);
        int          wait_cycles;
        int          req_before;
        logic        saw_stall;
        logic [31:0] exp_data;
        wait_cycles = 0;
        req_before  = req_count;
        saw_stall   = 1'b0;
        exp_data    = {e.addr[31:2], 2'b00} ^ MEM_KEY;
        busy_flag   = e.busy_hold;
        fetch_addr  = e.addr;
        fetch_req   = 1'b1;
        do begin
            @(posedge clk_tmp);
            #1;
            wait_cycles = wait_cycles + 1;
            if (miss_stall) begin
                saw_stall = 1'b1;
            end
            if (wait_cycles == 1) begin
                checks = checks + 1;
                if (miss_stall != e.exp_miss) begin
                    value_mismatch("miss_stall first cycle", 32'(miss_stall), 32'(e.exp_miss));
                end
            end
        end while (!fetch_done);
        checks = checks + 4;
        if (fetch_data != exp_data) begin
            value_mismatch("fetch_data", fetch_data, exp_data);
        end
        if (saw_stall != e.exp_miss) begin
            value_mismatch("miss_stall", 32'(saw_stall), 32'(e.exp_miss));
        end
        if (req_count - req_before != int'(e.exp_miss)) begin
            value_mismatch("l2_req count", 32'(req_count - req_before), 32'(e.exp_miss));
        end
        if (!e.exp_miss && wait_cycles != 1) begin
            value_mismatch("fetch_done latency", 32'(wait_cycles), 32'd1);
        end
        // request still held here, no new lookup may start while fetch_done is up
        @(posedge clk_tmp);
        #1;
        checks = checks + 1;
        if (fetch_done) begin
            $display("t=%0t fetch_done stayed high for more than one cycle", $time);
            errors = errors + 1;
        end
        fetch_req = 1'b0;
    endtask

    initial begin
        reset      = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        apply_reset();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (STIM[i].reset_first) begin
                apply_reset();
            end
            run_access(STIM[i]);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
hdl/icache_pkg.sv
hdl/cache_array_if.sv
hdl/icache_ctrl.sv
hdl/refill_counter.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_top.sv
bench/icache_tb.sv

//--- Makefile
TOP := icache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir
